/* dlxPkg.sv */
package dlxPkg;

   // ##################################################
   // Field widths and positions
   // ##################################################

   localparam int dataWidth     = 32;
   localparam int regAddrWidth  = 5;
   localparam int numRegs       = 32;

   localparam int exCtrlWidth   = 5;   // Class in the top two bits, ALU/branch bits below
   localparam int memCtrlWidth  = 3;
   localparam int wbCtrlWidth   = 3;
   localparam int classWidth    = 2;

   localparam int opcodeWidth   = 6;
   localparam int funcWidth     = 6;
   localparam int opcodeLsb     = 26;
   localparam int rs1Lsb        = 21;
   localparam int rs2Lsb        = 16;

   // Short form for I-type words, long form for the J offset
   localparam int immShortWidth = 16;
   localparam int immLongWidth  = 26;

   // The all-zero word is an FSEL encoding that decodes to no operation
   localparam logic [dataWidth-1:0] nopWord = '0;

   // ##################################################
   // Encodings
   // ##################################################

   typedef enum logic [opcodeWidth-1:0] {
      opFsel = 6'h00,
      opJ    = 6'h02,
      opBeqz = 6'h04,
      opBnez = 6'h05,
      opAddi = 6'h08,
      opLw   = 6'h23,
      opSw   = 6'h2B,
      opHlt  = 6'h3F
   } opcodeT;

   // Function field of an FSEL word
   typedef enum logic [funcWidth-1:0] {
      fnSll = 6'h04,
      fnSrl = 6'h06,
      fnAdd = 6'h20
   } funcT;

   // Instruction class seen by the execute stage
   typedef enum logic [classWidth-1:0] {
      clsRtype  = 2'd0,
      clsItype  = 2'd1,
      clsBranch = 2'd2,
      clsMemacc = 2'd3
   } exClassT;

endpackage

/* controlDecoder.sv */
module controlDecoder (
   input  logic [dlxPkg::dataWidth-1:0]    ir,
   output logic [dlxPkg::exCtrlWidth-1:0]  exCtrl,
   output logic [dlxPkg::memCtrlWidth-1:0] memCtrl,
   output logic [dlxPkg::wbCtrlWidth-1:0]  wbCtrl,
   output logic                            seSel,
   output logic                            isHalt
);
   import dlxPkg::*;

   opcodeT opcode;
   funcT   func;

   assign opcode = opcodeT'(ir[opcodeLsb +: opcodeWidth]);
   assign func   = funcT'(ir[funcWidth-1:0]);

   // ##################################################
   // Opcode decode
   // ##################################################

   always_comb begin
      exCtrl  = '0;
      memCtrl = '0;
      wbCtrl  = '0;
      seSel   = 1'b0;
      isHalt  = 1'b0;

      if (ir != nopWord) begin   // NOP keeps every control at zero
         case (opcode)
            opFsel: begin
               case (func)
                  fnSll, fnSrl: begin
                     exCtrl = {clsRtype, 3'b011};   // Shifts use the shifter path
                     wbCtrl = 3'b111;
                  end
                  default: begin
                     exCtrl = {clsRtype, 3'b010};
                     wbCtrl = 3'b111;
                  end
               endcase
            end
            opJ: begin
               exCtrl  = {clsBranch, 3'b001};
               memCtrl = 3'b010;
               seSel   = 1'b1;   // Jump takes the 26-bit offset
            end
            opBeqz: begin
               exCtrl  = {clsBranch, 3'b001};
               memCtrl = 3'b001;
            end
            opBnez: begin
               exCtrl  = {clsBranch, 3'b101};   // Top bit inverts the zero test
               memCtrl = 3'b001;
            end
            opAddi: begin
               exCtrl = {clsItype, 3'b011};
               wbCtrl = 3'b101;
            end
            opLw: begin
               exCtrl = {clsMemacc, 3'b011};
               wbCtrl = 3'b100;
            end
            opSw: begin
               exCtrl  = {clsMemacc, 3'b011};
               memCtrl = 3'b100;
            end
            opHlt: begin
               isHalt = 1'b1;
            end
            default: begin
               exCtrl = '0;   // Unknown opcodes behave as NOP
            end
         endcase
      end
   end

   // ##################################################
   // Checks
   // ##################################################

   // Only a jump selects the long offset and it never stops the machine
   assert property (@(ir) !(seSel === 1'b1 && isHalt === 1'b1))
      else $error("seSel and isHalt both high");

   // Branch and jump requests in MEM control come only with the branch class
   assert property (@(ir)
      (memCtrl != '0 && memCtrl != 3'b100) |->
         exCtrl[exCtrlWidth-1 -: classWidth] == clsBranch)
      else $error("MEM branch request without branch class");

endmodule

/* registerFile.sv */
module registerFile (
   input  logic                             Clk,
   input  logic [dlxPkg::dataWidth-1:0]     ir,
   input  logic                             wbWrite,
   input  logic [dlxPkg::regAddrWidth-1:0]  wbAddr,
   input  logic [dlxPkg::dataWidth-1:0]     wbData,
   output logic [dlxPkg::dataWidth-1:0]     readA,
   output logic [dlxPkg::dataWidth-1:0]     readB
);
   import dlxPkg::*;

   // Register 0 has no storage
   logic [dataWidth-1:0]    regs [1:numRegs-1];
   logic [regAddrWidth-1:0] rs1;
   logic [regAddrWidth-1:0] rs2;

   assign rs1 = ir[rs1Lsb +: regAddrWidth];
   assign rs2 = ir[rs2Lsb +: regAddrWidth];

   // One read port, with the write of this cycle passed straight through
   function automatic logic [dataWidth-1:0] readReg(input logic [regAddrWidth-1:0] addr);
      logic [dataWidth-1:0] value;
      if (addr == '0) begin
         value = '0;
      end else if (wbWrite && wbAddr == addr) begin
         value = wbData;
      end else begin
         value = regs[addr];
      end
      return value;
   endfunction

   always_comb begin
      readA = readReg(rs1);
   end

   always_comb begin
      readB = readReg(rs2);
   end

   // ##################################################
   // Write port
   // ##################################################

   always_ff @(posedge Clk) begin
      if (wbWrite && wbAddr != '0) begin   // Writes to r0 are dropped
         regs[wbAddr] <= wbData;
      end
   end

endmodule

/* idExLatch.sv */
module idExLatch (
   input  logic                            Clk,
   input  logic                            reset,
   input  logic                            irValid,
   input  logic [dlxPkg::dataWidth-1:0]    ir,
   input  logic [dlxPkg::exCtrlWidth-1:0]  decExCtrl,
   input  logic [dlxPkg::memCtrlWidth-1:0] decMemCtrl,
   input  logic [dlxPkg::wbCtrlWidth-1:0]  decWbCtrl,
   input  logic                            seSel,
   input  logic                            isHalt,
   input  logic [dlxPkg::dataWidth-1:0]    readA,
   input  logic [dlxPkg::dataWidth-1:0]    readB,
   output logic [dlxPkg::exCtrlWidth-1:0]  exCtrl,
   output logic [dlxPkg::memCtrlWidth-1:0] memCtrl,
   output logic [dlxPkg::wbCtrlWidth-1:0]  wbCtrl,
   output logic [dlxPkg::dataWidth-1:0]    operandA,
   output logic [dlxPkg::dataWidth-1:0]    operandB,
   output logic [dlxPkg::dataWidth-1:0]    immediate,
   output logic                            exValid,
   output logic                            halted
);
   import dlxPkg::*;

   logic [dataWidth-1:0] immNext;
   logic                 accept;

   // Sign extension from bit 25 for the jump offset, bit 15 otherwise
   assign immNext = seSel ?
      {{(dataWidth-immLongWidth){ir[immLongWidth-1]}}, ir[immLongWidth-1:0]} :
      {{(dataWidth-immShortWidth){ir[immShortWidth-1]}}, ir[immShortWidth-1:0]};

   assign accept = irValid && !halted;   // Strobes are ignored once halted

   // ##################################################
   // ID/EX register
   // ##################################################

   always_ff @(posedge Clk) begin
      if (reset) begin
         exCtrl    <= '0;
         memCtrl   <= '0;
         wbCtrl    <= '0;
         operandA  <= '0;
         operandB  <= '0;
         immediate <= '0;
         exValid   <= 1'b0;
         halted    <= 1'b0;
      end else begin
         exValid <= accept;
         if (accept) begin
            exCtrl    <= decExCtrl;
            memCtrl   <= decMemCtrl;
            wbCtrl    <= decWbCtrl;
            operandA  <= readA;
            operandB  <= readB;
            immediate <= immNext;
            if (isHalt) begin
               halted <= 1'b1;   // Held until the next reset
            end
         end
      end
   end

   // Halt is sticky and only a reset releases it
   assert property (@(posedge Clk) $fell(halted) |-> $past(reset))
      else $error("halted dropped without reset");

   // A halted stage issues nothing to execute
   assert property (@(posedge Clk) $past(halted) |-> !exValid)
      else $error("exValid raised while halted");

endmodule

/* decodeStage.sv */
module decodeStage (
   input  logic                             Clk,
   input  logic                             reset,
   input  logic [dlxPkg::dataWidth-1:0]     ir,
   input  logic                             irValid,
   input  logic                             wbWrite,
   input  logic [dlxPkg::regAddrWidth-1:0]  wbAddr,
   input  logic [dlxPkg::dataWidth-1:0]     wbData,
   output logic [dlxPkg::exCtrlWidth-1:0]   exCtrl,
   output logic [dlxPkg::memCtrlWidth-1:0]  memCtrl,
   output logic [dlxPkg::wbCtrlWidth-1:0]   wbCtrl,
   output logic [dlxPkg::dataWidth-1:0]     operandA,
   output logic [dlxPkg::dataWidth-1:0]     operandB,
   output logic [dlxPkg::dataWidth-1:0]     immediate,
   output logic                             exValid,
   output logic                             halted
);
   import dlxPkg::*;

   logic [exCtrlWidth-1:0]  decExCtrl;
   logic [memCtrlWidth-1:0] decMemCtrl;
   logic [wbCtrlWidth-1:0]  decWbCtrl;
   logic                    seSel;
   logic                    isHalt;
   logic [dataWidth-1:0]    readA;
   logic [dataWidth-1:0]    readB;

   // Decode and register read run side by side on the same word
   controlDecoder decoder0 (
      .ir      (ir),
      .exCtrl  (decExCtrl),
      .memCtrl (decMemCtrl),
      .wbCtrl  (decWbCtrl),
      .seSel   (seSel),
      .isHalt  (isHalt)
   );

   registerFile regFile0 (
      .Clk     (Clk),
      .ir      (ir),
      .wbWrite (wbWrite),
      .wbAddr  (wbAddr),
      .wbData  (wbData),
      .readA   (readA),
      .readB   (readB)
   );

   idExLatch latch0 (
      .Clk(Clk), .reset(reset), .irValid(irValid), .ir(ir),
      .decExCtrl(decExCtrl), .decMemCtrl(decMemCtrl), .decWbCtrl(decWbCtrl),
      .seSel(seSel), .isHalt(isHalt), .readA(readA), .readB(readB),
      .exCtrl(exCtrl), .memCtrl(memCtrl), .wbCtrl(wbCtrl),
      .operandA(operandA), .operandB(operandB), .immediate(immediate),
      .exValid(exValid), .halted(halted)
   );

endmodule

/* decodeStageTb.sv */
module decodeStageTb;
   import dlxPkg::*;

   localparam int numRows      = 16;
   localparam int cyclesPerRow = 2;
   localparam int setupCycles  = 2 + numRegs + 16;   // Reset, register load, halt and re-reset
   localparam int clkPeriod    = 100;
   localparam int timeLimit    = (numRows * cyclesPerRow + setupCycles + 20) * clkPeriod;

   logic                    Clk;
   logic                    reset;
   logic [dataWidth-1:0]    ir;
   logic                    irValid;
   logic                    wbWrite;
   logic [regAddrWidth-1:0] wbAddr;
   logic [dataWidth-1:0]    wbData;
   logic [exCtrlWidth-1:0]  exCtrl;
   logic [memCtrlWidth-1:0] memCtrl;
   logic [wbCtrlWidth-1:0]  wbCtrl;
   logic [dataWidth-1:0]    operandA;
   logic [dataWidth-1:0]    operandB;
   logic [dataWidth-1:0]    immediate;
   logic                    exValid;
   logic                    halted;

   logic [31:0] seed;
   logic [31:0] regModel [0:numRegs-1];

   // Stimulus table with one entry per row
   logic [31:0] rowIr   [0:numRows-1];
   logic [4:0]  rowEx   [0:numRows-1];
   logic [2:0]  rowMem  [0:numRows-1];
   logic [2:0]  rowWb   [0:numRows-1];
   logic        rowLong [0:numRows-1];   // Immediate taken from the 26-bit field
   logic        rowHalt [0:numRows-1];
   logic        rowWrEn [0:numRows-1];   // Write-back in the same cycle as the strobe
   logic [4:0]  rowWrAddr [0:numRows-1];

   always #(clkPeriod / 2) Clk = ~Clk;

   decodeStage dut0 (
      .Clk(Clk), .reset(reset), .ir(ir), .irValid(irValid),
      .wbWrite(wbWrite), .wbAddr(wbAddr), .wbData(wbData),
      .exCtrl(exCtrl), .memCtrl(memCtrl), .wbCtrl(wbCtrl),
      .operandA(operandA), .operandB(operandB), .immediate(immediate),
      .exValid(exValid), .halted(halted)
   );

   // ##################################################
   // Helpers
   // ##################################################

   function automatic logic [31:0] lcgNext(input logic [31:0] state);
      return state * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic logic [31:0] rtypeWord(input logic [4:0] rs1, input logic [4:0] rs2,
                                             input logic [4:0] rd, input logic [5:0] func);
      return {6'h00, rs1, rs2, rd, 5'd0, func};
   endfunction

   function automatic logic [31:0] itypeWord(input logic [5:0] op, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [15:0] imm);
      return {op, rs1, rs2, imm};
   endfunction

   function automatic logic [31:0] expectImm(input logic [31:0] word, input logic isLong);
      if (isLong) begin
         return {{6{word[25]}}, word[25:0]};
      end
      return {{16{word[15]}}, word[15:0]};
   endfunction

   task automatic checkValue(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
      if (actual !== expected) begin
         $display("[FAIL] %s actual %h expected %h", name, actual, expected);
         $display("TEST FAILED");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic addRow(input int r, input logic [31:0] word, input logic [4:0] ex,
                         input logic [2:0] mem, input logic [2:0] wb, input logic isLong,
                         input logic endsHalt, input logic wrEn, input logic [4:0] wrAddr);
      rowIr[r]     = word;
      rowEx[r]     = ex;
      rowMem[r]    = mem;
      rowWb[r]     = wb;
      rowLong[r]   = isLong;
      rowHalt[r]   = endsHalt;
      rowWrEn[r]   = wrEn;
      rowWrAddr[r] = wrAddr;
   endtask

   task automatic fillTable;
      addRow(0,  rtypeWord(5'd3, 5'd4, 5'd5, 6'h04), 5'b00011, 3'b000, 3'b111, 0, 0, 0, 0);
      addRow(1,  rtypeWord(5'd8, 5'd1, 5'd2, 6'h06), 5'b00011, 3'b000, 3'b111, 0, 0, 0, 0);
      addRow(2,  rtypeWord(5'd11, 5'd14, 5'd1, 6'h20), 5'b00010, 3'b000, 3'b111, 0, 0, 0, 0);
      addRow(3,  rtypeWord(5'd20, 5'd21, 5'd9, 6'h22), 5'b00010, 3'b000, 3'b111, 0, 0, 0, 0);
      addRow(4,  {6'h02, 26'h3FFFF00}, 5'b10001, 3'b010, 3'b000, 1, 0, 0, 0);   // Jump back
      addRow(5,  itypeWord(6'h04, 5'd7, 5'd0, 16'h0010), 5'b10001, 3'b001, 3'b000, 0, 0, 0, 0);
      addRow(6,  itypeWord(6'h05, 5'd7, 5'd0, 16'hFFF0), 5'b10101, 3'b001, 3'b000, 0, 0, 0, 0);
      addRow(7,  itypeWord(6'h08, 5'd9, 5'd10, 16'h1234), 5'b01011, 3'b000, 3'b101, 0, 0, 0, 0);
      addRow(8,  itypeWord(6'h08, 5'd15, 5'd16, 16'h8001), 5'b01011, 3'b000, 3'b101, 0, 0, 0, 0);
      addRow(9,  itypeWord(6'h23, 5'd31, 5'd2, 16'h7FFC), 5'b11011, 3'b000, 3'b100, 0, 0, 0, 0);
      addRow(10, itypeWord(6'h2B, 5'd0, 5'd12, 16'hFFFC), 5'b11011, 3'b100, 3'b000, 0, 0, 0, 0);
      addRow(11, 32'h0000_0000, 5'b00000, 3'b000, 3'b000, 0, 0, 0, 0);
      addRow(12, itypeWord(6'h3A, 5'd1, 5'd2, 16'h0005), 5'b00000, 3'b000, 3'b000, 0, 0, 0, 0);
      addRow(13, itypeWord(6'h08, 5'd6, 5'd17, 16'h0042), 5'b01011, 3'b000, 3'b101, 0, 0, 1, 6);
      addRow(14, rtypeWord(5'd0, 5'd13, 5'd4, 6'h20), 5'b00010, 3'b000, 3'b111, 0, 0, 1, 0);
      addRow(15, 32'hFC22_8005, 5'b00000, 3'b000, 3'b000, 0, 1, 0, 0);   // Halt with live fields
   endtask

   task automatic loadRegisters;
      for (int i = 1; i < numRegs; i++) begin
         @(posedge Clk);
         seed = lcgNext(seed);
         regModel[i] = seed;
         wbWrite <= 1'b1;
         wbAddr  <= i[4:0];
         wbData  <= seed;
      end
      @(posedge Clk);
      wbWrite <= 1'b0;
   endtask

   task automatic applyRow(input int r);
      logic [31:0] word;
      word = rowIr[r];
      @(posedge Clk);
      ir      <= word;
      irValid <= 1'b1;
      if (rowWrEn[r]) begin
         seed = lcgNext(seed);
         if (rowWrAddr[r] != 5'd0) begin
            regModel[rowWrAddr[r]] = seed;   // Register 0 stays zero
         end
         wbWrite <= 1'b1;
         wbAddr  <= rowWrAddr[r];
         wbData  <= seed;
      end
      @(posedge Clk);
      irValid <= 1'b0;
      wbWrite <= 1'b0;
      @(negedge Clk);
      checkValue("exValid", exValid, 1);
      checkValue("exCtrl", exCtrl, rowEx[r]);
      checkValue("memCtrl", memCtrl, rowMem[r]);
      checkValue("wbCtrl", wbCtrl, rowWb[r]);
      checkValue("operandA", operandA, regModel[word[25:21]]);
      checkValue("operandB", operandB, regModel[word[20:16]]);
      checkValue("immediate", immediate, expectImm(word, rowLong[r]));
      checkValue("halted", halted, rowHalt[r]);
   endtask

   // Every latch output comes out of reset at zero
   task automatic checkCleared;
      checkValue("halted", halted, 0);
      checkValue("exValid", exValid, 0);
      checkValue("exCtrl", exCtrl, 0);
      checkValue("memCtrl", memCtrl, 0);
      checkValue("wbCtrl", wbCtrl, 0);
      checkValue("operandA", operandA, 0);
      checkValue("operandB", operandB, 0);
      checkValue("immediate", immediate, 0);
   endtask

   // Strobes after a halt must leave every output where it was
   task automatic strobeWhileHalted;
      logic [31:0] heldA;
      logic [31:0] heldImm;
      logic [4:0]  heldEx;
      heldA   = operandA;
      heldImm = immediate;
      heldEx  = exCtrl;
      repeat (2) begin
         @(posedge Clk);
         ir      <= rowIr[7];
         irValid <= 1'b1;
         @(posedge Clk);
         irValid <= 1'b0;
         @(negedge Clk);
         checkValue("exValid", exValid, 0);
         checkValue("halted", halted, 1);
         checkValue("exCtrl", exCtrl, heldEx);
         checkValue("operandA", operandA, heldA);
         checkValue("immediate", immediate, heldImm);
      end
   endtask

   // ##################################################
   // Main sequence
   // ##################################################

   initial begin
      Clk     = 1'b0;
      reset   = 1'b1;
      ir      = '0;
      irValid = 1'b0;
      wbWrite = 1'b0;
      wbAddr  = '0;
      wbData  = '0;
      seed    = 32'd5176;
      regModel[0] = '0;
      fillTable();

      repeat (2) @(posedge Clk);
      reset <= 1'b0;
      @(negedge Clk);
      checkCleared();
      loadRegisters();

      for (int r = 0; r < numRows; r++) begin
         applyRow(r);
      end
      strobeWhileHalted();

      @(posedge Clk);
      reset <= 1'b1;
      repeat (2) @(posedge Clk);
      reset <= 1'b0;
      @(negedge Clk);
      checkCleared();
      applyRow(7);   // Decoding resumes after reset

      $display("TEST OK");
      $finish;
   end

   initial begin
      #(timeLimit);
      $display("Timeout: the run took longer than the tests allow");
      $display("TEST FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule

/* compile.f */
dlxPkg.sv
controlDecoder.sv
registerFile.sv
idExLatch.sv
decodeStage.sv
decodeStageTb.sv
